// File: hdl/fpFormatPkg.sv
// memory formats: data bus width, single and double field widths, biases, format selector
package fpFormatPkg;

  // memory data bus, a single sits in the low half
  localparam int MEM_WIDTH = 64;

  // IEEE single fields
  localparam int SGL_EXP_W  = 8;
  localparam int SGL_FRAC_W = 23;

  // IEEE double fields
  localparam int DBL_EXP_W  = 11;
  localparam int DBL_FRAC_W = 52;

  // exponent biases of the memory formats
  localparam int SGL_BIAS = 127;
  localparam int DBL_BIAS = 1023;

  // memory format of one load or store transfer
  typedef enum logic {
    FMT_SINGLE = 1'b0,
    FMT_DOUBLE = 1'b1
  } memFmtT;

endpackage

// File: hdl/fpNativePkg.sv
// native register format: field widths, exponent bias, special exponent code, helper widths
package fpNativePkg;

  // sign, exponent, significand from the top down
  localparam int NAT_WIDTH = 80;
  localparam int NAT_EXP_W = 15;

  // significand with the explicit integer bit at its top
  localparam int NAT_SIG_W = 64;

  // fraction bits below the integer bit
  localparam int NAT_FRAC_W = NAT_SIG_W - 1;

  localparam int NAT_BIAS = 16383;

  // all ones exponent marks infinity or NaN
  localparam logic [NAT_EXP_W-1:0] NAT_EXP_MAX = '1;

  // shift counts across the whole significand
  localparam int NAT_SHIFT_W = $clog2(NAT_SIG_W);

  // signed width for rebiased exponents, with headroom for under and overflow
  localparam int NAT_CALC_W = NAT_EXP_W + 2;

endpackage

// File: hdl/leadingOneFind.sv
// priority encoder returning the index of the highest set bit
`timescale 1ns/1ps

module leadingOneFind #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0]         vec,
  output logic [$clog2(WIDTH)-1:0] pos,
  output logic                     found
);

  // scan upward so the most significant set bit wins
  always_comb begin
    pos   = '0;
    found = 1'b0;
    for (int i = 0; i < WIDTH; i++) begin
      if (vec[i]) begin
        pos   = i[$clog2(WIDTH)-1:0];
        found = 1'b1;
      end
    end
  end

endmodule

// File: hdl/loadConvert.sv
// registered widening of a memory single or double into the native format
`timescale 1ns/1ps

module loadConvert
  import fpFormatPkg::*;
  import fpNativePkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 ldValid,
  input  memFmtT               ldFmt,
  input  logic [MEM_WIDTH-1:0] ldData,
  output logic                 ldResValid,
  output logic [NAT_WIDTH-1:0] ldRes
);

  // fractions placed directly under the integer bit
  logic [NAT_FRAC_W-1:0] sglFracAl;
  logic [NAT_FRAC_W-1:0] dblFracAl;

  logic [$clog2(SGL_FRAC_W)-1:0] sglPos;
  logic [$clog2(DBL_FRAC_W)-1:0] dblPos;
  logic                          sglFound;
  logic                          dblFound;

  // format-independent view of the selected input
  logic                   sign;
  logic [NAT_EXP_W-1:0]   memExp;
  logic                   expMax;
  logic [NAT_FRAC_W-1:0]  fracAl;
  logic                   fracFound;
  logic [NAT_SHIFT_W-1:0] normShift;
  logic [NAT_EXP_W-1:0]   rebias;

  logic [NAT_EXP_W-1:0] natExp;
  logic [NAT_SIG_W-1:0] natSig;

  assign sglFracAl = {ldData[SGL_FRAC_W-1:0], {(NAT_FRAC_W-SGL_FRAC_W){1'b0}}};
  assign dblFracAl = {ldData[DBL_FRAC_W-1:0], {(NAT_FRAC_W-DBL_FRAC_W){1'b0}}};

  // leading one of each fraction is only consulted for denormals
  leadingOneFind #(.WIDTH(DBL_FRAC_W)) u_dblLead (
    .vec   (ldData[DBL_FRAC_W-1:0]),
    .pos   (dblPos),
    .found (dblFound)
  );

  leadingOneFind #(.WIDTH(SGL_FRAC_W)) u_sglLead (
    .vec   (ldData[SGL_FRAC_W-1:0]),
    .pos   (sglPos),
    .found (sglFound)
  );

  always_comb begin
    if (ldFmt == FMT_DOUBLE) begin
      sign      = ldData[MEM_WIDTH-1];
      memExp    = NAT_EXP_W'(ldData[DBL_FRAC_W +: DBL_EXP_W]);
      expMax    = &ldData[DBL_FRAC_W +: DBL_EXP_W];
      fracAl    = dblFracAl;
      fracFound = dblFound;
      normShift = NAT_SHIFT_W'(DBL_FRAC_W) - NAT_SHIFT_W'(dblPos);
      rebias    = NAT_EXP_W'(NAT_BIAS - DBL_BIAS);
    end else begin
      sign      = ldData[SGL_EXP_W+SGL_FRAC_W];
      memExp    = NAT_EXP_W'(ldData[SGL_FRAC_W +: SGL_EXP_W]);
      expMax    = &ldData[SGL_FRAC_W +: SGL_EXP_W];
      fracAl    = sglFracAl;
      fracFound = sglFound;
      normShift = NAT_SHIFT_W'(SGL_FRAC_W) - NAT_SHIFT_W'(sglPos);
      rebias    = NAT_EXP_W'(NAT_BIAS - SGL_BIAS);
    end
  end

  // normal numbers by default with specials overriding
  always_comb begin
    natExp = memExp + rebias;
    natSig = {1'b1, fracAl};
    if (expMax) begin
      // infinity or NaN keeps its fraction
      natExp = NAT_EXP_MAX;
    end else if (memExp == '0) begin
      if (fracFound) begin
        // move a denormal's leading one up to the integer bit
        natExp = rebias + NAT_EXP_W'(1) - NAT_EXP_W'(normShift);
        natSig = {1'b0, fracAl} << normShift;
      end else begin
        natExp = '0;
        natSig = '0;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ldResValid <= 1'b0;
      ldRes      <= '0;
    end else begin
      ldResValid <= ldValid;
      if (ldValid) begin
        ldRes <= {sign, natExp, natSig};
      end
    end
  end

endmodule

// File: hdl/storeConvert.sv
// registered narrowing of a native value into a memory single or double
`timescale 1ns/1ps

module storeConvert
  import fpFormatPkg::*;
  import fpNativePkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 stValid,
  input  memFmtT               stFmt,
  input  logic [NAT_WIDTH-1:0] stData,
  output logic                 stResValid,
  output logic [MEM_WIDTH-1:0] stRes
);

  // native fields
  logic                 sign;
  logic [NAT_EXP_W-1:0] natExp;
  logic [NAT_SIG_W-1:0] sig;
  logic                 natExpMax;
  logic                 fracNonZero;

  // limits of the selected memory format
  logic signed [NAT_CALC_W-1:0] memBias;
  logic signed [NAT_CALC_W-1:0] memExpMax;
  logic signed [NAT_CALC_W-1:0] denLow;

  logic signed [NAT_CALC_W-1:0] reExp;
  logic [NAT_SHIFT_W-1:0]       denShift;
  logic [NAT_SIG_W-1:0]         shiftedSig;

  // results built at double width with a single in the top fraction bits
  logic [DBL_FRAC_W-1:0] truncFrac;
  logic [DBL_FRAC_W-1:0] denFrac;
  logic [DBL_EXP_W-1:0]  outExp;
  logic [DBL_FRAC_W-1:0] outFrac;
  logic [MEM_WIDTH-1:0]  memWord;

  assign sign        = stData[NAT_WIDTH-1];
  assign natExp      = stData[NAT_SIG_W +: NAT_EXP_W];
  assign sig         = stData[NAT_SIG_W-1:0];
  assign natExpMax   = natExp == NAT_EXP_MAX;
  assign fracNonZero = |sig[NAT_FRAC_W-1:0];

  always_comb begin
    if (stFmt == FMT_DOUBLE) begin
      memBias   = NAT_CALC_W'(DBL_BIAS);
      memExpMax = NAT_CALC_W'((1 << DBL_EXP_W) - 1);
      denLow    = NAT_CALC_W'(1 - DBL_FRAC_W);
    end else begin
      memBias   = NAT_CALC_W'(SGL_BIAS);
      memExpMax = NAT_CALC_W'((1 << SGL_EXP_W) - 1);
      denLow    = NAT_CALC_W'(1 - SGL_FRAC_W);
    end
  end

  // memory exponent that may fall below zero or past the maximum
  assign reExp = signed'(NAT_CALC_W'(natExp)) - NAT_CALC_W'(NAT_BIAS) + memBias;

  // only meaningful inside the denormal range where it runs from 1 to the fraction width
  assign denShift   = NAT_SHIFT_W'(1 - reExp);
  assign shiftedSig = sig >> denShift;

  // excess precision is dropped without rounding
  assign truncFrac = sig[NAT_FRAC_W-1 -: DBL_FRAC_W];
  assign denFrac   = shiftedSig[NAT_FRAC_W-1 -: DBL_FRAC_W];

  always_comb begin
    outExp  = '0;
    outFrac = '0;
    if (natExpMax && fracNonZero) begin
      // NaN leaves quiet
      outExp                = '1;
      outFrac               = truncFrac;
      outFrac[DBL_FRAC_W-1] = 1'b1;
    end else if (natExpMax || reExp >= memExpMax) begin
      outExp = '1;
    end else if (reExp > 0) begin
      outExp  = DBL_EXP_W'(reExp);
      outFrac = truncFrac;
    end else if (reExp >= denLow) begin
      outFrac = denFrac;
    end
    // anything lower stays signed zero
  end

  always_comb begin
    if (stFmt == FMT_DOUBLE) begin
      memWord = {sign, outExp, outFrac};
    end else begin
      memWord = {{(MEM_WIDTH-1-SGL_EXP_W-SGL_FRAC_W){1'b0}}, sign,
                 outExp[SGL_EXP_W-1:0], outFrac[DBL_FRAC_W-1 -: SGL_FRAC_W]};
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stResValid <= 1'b0;
      stRes      <= '0;
    end else begin
      stResValid <= stValid;
      if (stValid) begin
        stRes <= memWord;
      end
    end
  end

endmodule

// File: hdl/fpLdStConvert.sv
// top level with independent load and store format converters
`timescale 1ns/1ps

module fpLdStConvert
  import fpFormatPkg::*;
  import fpNativePkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,

  // load path from memory to native
  input  logic                 ldValid,
  input  memFmtT               ldFmt,
  input  logic [MEM_WIDTH-1:0] ldData,
  output logic                 ldResValid,
  output logic [NAT_WIDTH-1:0] ldRes,

  // store path from native to memory
  input  logic                 stValid,
  input  memFmtT               stFmt,
  input  logic [NAT_WIDTH-1:0] stData,
  output logic                 stResValid,
  output logic [MEM_WIDTH-1:0] stRes
);

  loadConvert u_load (
    .clk        (clk),
    .rstN       (rstN),
    .ldValid    (ldValid),
    .ldFmt      (ldFmt),
    .ldData     (ldData),
    .ldResValid (ldResValid),
    .ldRes      (ldRes)
  );

  storeConvert u_store (
    .clk        (clk),
    .rstN       (rstN),
    .stValid    (stValid),
    .stFmt      (stFmt),
    .stData     (stData),
    .stResValid (stResValid),
    .stRes      (stRes)
  );

endmodule

// File: verif/fpRefModel.svh
// reference functions: native encodings of memory values and memory encodings of native values
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// native word from sign, exponent and significand
function automatic logic [NAT_WIDTH-1:0] natPack(input logic sign, input int expo,
                                                 input logic [NAT_SIG_W-1:0] sig);
  return {sign, NAT_EXP_W'(expo), sig};
endfunction

// widening rules for either memory format, fraction given left-aligned under the integer bit
function automatic logic [NAT_WIDTH-1:0] widenToNative(input logic sign, input int memExp,
    input logic [NAT_FRAC_W-1:0] fracAl, input int expW, input int bias);
  logic [NAT_SIG_W-1:0] sig;
  int shifts;
  if (memExp == (1 << expW) - 1) begin
    return natPack(sign, NAT_EXP_MAX, {1'b1, fracAl});
  end
  if (memExp != 0) begin
    return natPack(sign, memExp - bias + NAT_BIAS, {1'b1, fracAl});
  end
  if (fracAl == '0) begin
    return natPack(sign, 0, '0);
  end
  // denormal worth 0.f * 2^(1-bias), slide the leading one up to the integer bit
  sig = {1'b0, fracAl};
  shifts = 0;
  while (!sig[NAT_SIG_W-1]) begin
    sig = sig << 1;
    shifts++;
  end
  return natPack(sign, NAT_BIAS + 1 - bias - shifts, sig);
endfunction

// expected load result, a single taken from the low half of the bus
function automatic logic [NAT_WIDTH-1:0] nativeFromMem(input memFmtT fmt,
                                                       input logic [MEM_WIDTH-1:0] w);
  if (fmt == FMT_DOUBLE) begin
    return widenToNative(w[63], int'(w[62:52]), {w[51:0], 11'b0}, DBL_EXP_W, DBL_BIAS);
  end
  return widenToNative(w[31], int'(w[30:23]), {w[22:0], 40'b0}, SGL_EXP_W, SGL_BIAS);
endfunction

// expected store result, truncating toward zero
function automatic logic [MEM_WIDTH-1:0] memFromNative(input memFmtT fmt,
                                                       input logic [NAT_WIDTH-1:0] n);
  int expW;
  int fracW;
  int bias;
  int natExp;
  int reExp;
  int expAllOnes;
  logic [NAT_SIG_W-1:0] sig;
  logic [MEM_WIDTH-1:0] expField;
  logic [MEM_WIDTH-1:0] frac;
  expW       = (fmt == FMT_DOUBLE) ? DBL_EXP_W : SGL_EXP_W;
  fracW      = (fmt == FMT_DOUBLE) ? DBL_FRAC_W : SGL_FRAC_W;
  bias       = (fmt == FMT_DOUBLE) ? DBL_BIAS : SGL_BIAS;
  natExp     = int'(n[NAT_WIDTH-2 -: NAT_EXP_W]);
  sig        = n[NAT_SIG_W-1:0];
  expAllOnes = (1 << expW) - 1;
  reExp      = natExp - NAT_BIAS + bias;
  expField   = '0;
  frac       = '0;
  if (natExp == int'(NAT_EXP_MAX) && sig[NAT_FRAC_W-1:0] != '0) begin
    // quiet NaN
    expField = expAllOnes;
    frac = MEM_WIDTH'(sig[NAT_FRAC_W-1:0]) >> (NAT_FRAC_W - fracW);
    frac[fracW-1] = 1'b1;
  end else if (natExp == int'(NAT_EXP_MAX) || reExp >= expAllOnes) begin
    expField = expAllOnes;
  end else if (reExp >= 1) begin
    expField = reExp;
    frac = MEM_WIDTH'(sig[NAT_FRAC_W-1:0]) >> (NAT_FRAC_W - fracW);
  end else if (reExp >= 1 - fracW) begin
    // integer bit moves down into the fraction
    frac = (sig >> (1 - reExp)) >> (NAT_FRAC_W - fracW);
  end
  return (MEM_WIDTH'(n[NAT_WIDTH-1]) << (expW + fracW)) | (expField << fracW) | frac;
endfunction

`endif

// File: verif/tbFpLdStConvert.sv
// testbench for the load/store format converters: clock, reset, watchdog, directed tests
`timescale 1ns/1ps

module tbFpLdStConvert
  import fpFormatPkg::*;
  import fpNativePkg::*;
();

  localparam int HALF_PERIOD   = 4;
  localparam int CLK_PERIOD    = 2 * HALF_PERIOD;
  localparam int RESET_CYCLES  = 3;
  localparam int DIRECTED_REQS = 53;
  localparam int RANDOM_REQS   = 64;
  // two cycles per directed request and one per random item plus drain
  localparam int RUN_CYCLES    = RESET_CYCLES + 2 * DIRECTED_REQS + RANDOM_REQS + 4;
  localparam int WATCHDOG_NS   = RUN_CYCLES * CLK_PERIOD + 500;

  logic                 clk;
  logic                 rstN;
  logic                 ldValid;
  memFmtT               ldFmt;
  logic [MEM_WIDTH-1:0] ldData;
  logic                 ldResValid;
  logic [NAT_WIDTH-1:0] ldRes;
  logic                 stValid;
  memFmtT               stFmt;
  logic [NAT_WIDTH-1:0] stData;
  logic                 stResValid;
  logic [MEM_WIDTH-1:0] stRes;

  int checks = 0;
  int errors = 0;

  `include "fpRefModel.svh"

  fpLdStConvert u_dut (
    .clk        (clk),
    .rstN       (rstN),
    .ldValid    (ldValid),
    .ldFmt      (ldFmt),
    .ldData     (ldData),
    .ldResValid (ldResValid),
    .ldRes      (ldRes),
    .stValid    (stValid),
    .stFmt      (stFmt),
    .stData     (stData),
    .stResValid (stResValid),
    .stRes      (stRes)
  );

  always #HALF_PERIOD clk = ~clk;

  task automatic compareWord(input string name, input logic [NAT_WIDTH-1:0] expected,
                             input logic [NAT_WIDTH-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic strobeCheck(input string name, input string which, input logic actual,
                             input logic expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      if (expected)
        $display("%s: %s result strobe missing one cycle after the request", name, which);
      else
        $display("%s: %s result strobe high with no request in the cycle before", name, which);
    end
  endtask

  // one load request with its result one cycle later and the strobe gone after that
  task automatic runLoad(input string test, input memFmtT fmt, input logic [MEM_WIDTH-1:0] data);
    string name;
    name    = $sformatf("%s %h", test, data);
    ldValid = 1'b1;
    ldFmt   = fmt;
    ldData  = data;
    @(posedge clk);
    #1;
    ldValid = 1'b0;
    strobeCheck(name, "load", ldResValid, 1'b1);
    compareWord(name, nativeFromMem(fmt, data), ldRes);
    @(posedge clk);
    #1;
    strobeCheck(name, "load", ldResValid, 1'b0);
  endtask

  task automatic runStore(input string test, input memFmtT fmt, input logic [NAT_WIDTH-1:0] data);
    string name;
    name    = $sformatf("%s %s %h", test, fmt.name(), data);
    stValid = 1'b1;
    stFmt   = fmt;
    stData  = data;
    @(posedge clk);
    #1;
    stValid = 1'b0;
    strobeCheck(name, "store", stResValid, 1'b1);
    compareWord(name, NAT_WIDTH'(memFromNative(fmt, data)), NAT_WIDTH'(stRes));
    @(posedge clk);
    #1;
    strobeCheck(name, "store", stResValid, 1'b0);
  endtask

  task automatic loadNormals();
    runLoad("load normal", FMT_SINGLE, 64'h3F80_0000);
    runLoad("load normal", FMT_SINGLE, 64'hC020_0000);
    runLoad("load normal", FMT_SINGLE, 64'h7F7F_FFFF);
    runLoad("load normal", FMT_SINGLE, 64'h0080_0000);
    runLoad("load normal", FMT_DOUBLE, 64'h3FF0_0000_0000_0000);
    runLoad("load normal", FMT_DOUBLE, 64'hBFB9_9999_9999_999A);
    runLoad("load normal", FMT_DOUBLE, 64'h7FEF_FFFF_FFFF_FFFF);
    runLoad("load normal", FMT_DOUBLE, 64'h0010_0000_0000_0000);
    // upper half of the bus must not leak into a single
    runLoad("load single upper bits", FMT_SINGLE, 64'hDEAD_BEEF_3F80_0000);
  endtask

  task automatic loadDenormals();
    runLoad("load denormal", FMT_SINGLE, 64'h0000_0001);
    runLoad("load denormal", FMT_SINGLE, 64'h0040_0000);
    runLoad("load denormal", FMT_SINGLE, 64'h807F_FFFF);
    runLoad("load denormal", FMT_DOUBLE, 64'h0000_0000_0000_0001);
    runLoad("load denormal", FMT_DOUBLE, 64'h000F_FFFF_FFFF_FFFF);
    runLoad("load denormal", FMT_DOUBLE, 64'h8008_0000_0000_0000);
    runLoad("load zero", FMT_SINGLE, 64'h8000_0000);
    runLoad("load zero", FMT_SINGLE, 64'h0000_0000);
    runLoad("load zero", FMT_DOUBLE, 64'h8000_0000_0000_0000);
    runLoad("load zero", FMT_DOUBLE, 64'h0000_0000_0000_0000);
  endtask

  task automatic loadSpecials();
    runLoad("load infinity", FMT_SINGLE, 64'h7F80_0000);
    runLoad("load infinity", FMT_SINGLE, 64'hFF80_0000);
    runLoad("load NaN", FMT_SINGLE, 64'h7FC0_0000);
    runLoad("load NaN", FMT_SINGLE, 64'h7F80_0001);
    runLoad("load infinity", FMT_DOUBLE, 64'h7FF0_0000_0000_0000);
    runLoad("load infinity", FMT_DOUBLE, 64'hFFF0_0000_0000_0000);
    runLoad("load NaN", FMT_DOUBLE, 64'h7FF8_0000_0000_0000);
    runLoad("load NaN", FMT_DOUBLE, 64'h7FF0_0000_0000_0123);
  endtask

  task automatic storeNormals();
    memFmtT fmt;
    // exponents inside the single range are normal in both formats
    for (int f = 0; f < 2; f++) begin
      fmt = memFmtT'(f);
      runStore("store normal", fmt, natPack(0, NAT_BIAS, '1));
      runStore("store normal", fmt, natPack(1, NAT_BIAS + 100, 64'hABCD_EF01_2345_6789));
      runStore("store normal", fmt, natPack(0, NAT_BIAS - 126, 64'h8000_0000_0000_07FF));
      runStore("store normal", fmt, natPack(1, NAT_BIAS + 127, 64'hFFFF_FF00_0000_0000));
    end
    runStore("store normal", FMT_DOUBLE, natPack(0, NAT_BIAS + 1023, '1));
    runStore("store normal", FMT_DOUBLE, natPack(1, NAT_BIAS - 1022, 64'h8000_0000_0000_0FFF));
  endtask

  task automatic storeOutOfRange();
    memFmtT fmt;
    runStore("store overflow", FMT_SINGLE, natPack(0, NAT_BIAS + 128, 64'h8000_0000_0000_0000));
    runStore("store overflow", FMT_DOUBLE, natPack(1, NAT_BIAS + 1024, 64'hC000_0000_0000_0000));
    runStore("store denormal", FMT_SINGLE, natPack(0, NAT_BIAS - 127, 64'hC000_0000_0000_0000));
    runStore("store denormal", FMT_SINGLE, natPack(1, NAT_BIAS - 149, 64'h8000_0000_0000_0000));
    runStore("store underflow", FMT_SINGLE, natPack(1, NAT_BIAS - 150, '1));
    runStore("store denormal", FMT_DOUBLE, natPack(0, NAT_BIAS - 1023, '1));
    runStore("store denormal", FMT_DOUBLE, natPack(1, NAT_BIAS - 1074, 64'h8000_0000_0000_0000));
    runStore("store underflow", FMT_DOUBLE, natPack(0, NAT_BIAS - 1075, '1));
    for (int f = 0; f < 2; f++) begin
      fmt = memFmtT'(f);
      runStore("store infinity", fmt, natPack(1, NAT_EXP_MAX, 64'h8000_0000_0000_0000));
      runStore("store NaN", fmt, natPack(0, NAT_EXP_MAX, 64'h8000_0000_0000_0001));
      runStore("store NaN", fmt, natPack(1, NAT_EXP_MAX, 64'hA000_0000_0000_0000));
      runStore("store zero", fmt, natPack(1, 0, '0));
    end
  endtask

  // back-to-back loads with each native result stored again in the following cycle
  task automatic roundTripRandom();
    logic [MEM_WIDTH-1:0] words[RANDOM_REQS];
    logic [MEM_WIDTH-1:0] busData[RANDOM_REQS];
    memFmtT               fmts[RANDOM_REQS];
    string                name;
    for (int i = 0; i < RANDOM_REQS; i++) begin
      fmts[i] = memFmtT'($urandom_range(1, 0));
      if (fmts[i] == FMT_DOUBLE) begin
        words[i]   = {1'($urandom), 11'($urandom_range(2046, 1)), 20'($urandom), $urandom};
        busData[i] = words[i];
      end else begin
        words[i]   = {32'h0, 1'($urandom), 8'($urandom_range(254, 1)), 23'($urandom)};
        busData[i] = {$urandom, words[i][31:0]};
      end
    end
    for (int i = 0; i < RANDOM_REQS + 2; i++) begin
      if (i >= 2) begin
        name = $sformatf("round trip store %0d", i - 2);
        strobeCheck(name, "store", stResValid, 1'b1);
        compareWord(name, NAT_WIDTH'(words[i-2]), NAT_WIDTH'(stRes));
      end
      if (i >= 1 && i <= RANDOM_REQS) begin
        name = $sformatf("round trip load %0d", i - 1);
        strobeCheck(name, "load", ldResValid, 1'b1);
        compareWord(name, nativeFromMem(fmts[i-1], busData[i-1]), ldRes);
        stValid = 1'b1;
        stFmt   = fmts[i-1];
        stData  = ldRes;
      end else begin
        stValid = 1'b0;
      end
      if (i < RANDOM_REQS) begin
        ldValid = 1'b1;
        ldFmt   = fmts[i];
        ldData  = busData[i];
      end else begin
        ldValid = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    strobeCheck("round trip drain", "load", ldResValid, 1'b0);
    strobeCheck("round trip drain", "store", stResValid, 1'b0);
  endtask

  initial begin
    #WATCHDOG_NS;
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h74374d11));
    clk     = 1'b0;
    rstN    = 1'b0;
    ldValid = 1'b0;
    ldFmt   = FMT_SINGLE;
    ldData  = '0;
    stValid = 1'b0;
    stFmt   = FMT_SINGLE;
    stData  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstN = 1'b1;
    // outputs still hold their reset values
    strobeCheck("after reset", "load", ldResValid, 1'b0);
    strobeCheck("after reset", "store", stResValid, 1'b0);
    compareWord("load data after reset", '0, ldRes);
    compareWord("store data after reset", '0, NAT_WIDTH'(stRes));
    loadNormals();
    loadDenormals();
    loadSpecials();
    storeNormals();
    storeOutOfRange();
    roundTripRandom();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+verif
hdl/fpFormatPkg.sv
hdl/fpNativePkg.sv
hdl/leadingOneFind.sv
hdl/loadConvert.sv
hdl/storeConvert.sv
hdl/fpLdStConvert.sv
verif/tbFpLdStConvert.sv
